// File: verilog/ctl_pkg.sv
// Shared definitions for the microcoded control unit
// Control word layout, sequencing opcodes, output bundles
// Micro-address constants and ROM geometry

package ctl_pkg;

    localparam int CTL_WIDTH = 31;                  // One microcode word
    localparam int ROM_DEPTH = 512;                 // Decode half plus sequencer half
    localparam int UPC_WIDTH = 9;                   // Micro-address bits
    localparam int FIN_WIDTH = 5;                   // Finisher slot bits

    localparam logic [UPC_WIDTH-1:0] UPC_RESET = 9'h160; // Reset sequence entry
    localparam logic [UPC_WIDTH-1:0] UPC_IRQ   = 9'h168; // Interrupt sequence entry
    localparam logic [1:0] UPC_FINISH_BASE     = 2'b10;  // Finishers at 140/1C0

    // What the sequencer does after this word
    typedef enum logic [1:0] {
        SEQ_DECODE    = 2'd0,                       // Fetch next opcode
        SEQ_NEXT      = 2'd1,                       // Follow next field
        SEQ_FINISH    = 2'd2,                       // Jump to saved finisher
        SEQ_NEXT_SAVE = 2'd3                        // Follow next, latch finisher
    } seq_op_e;

    // ALU control as stored in the ROM word
    typedef struct packed {
        logic [1:0] shift;
        logic [2:0] adder;
        logic [1:0] ci;                             // Carry-in select
    } alu_ctl_t;

    // ALU control in ALU port order
    typedef struct packed {
        logic [1:0] ci;
        logic [1:0] shift;
        logic [2:0] adder;
    } alu_op_t;

    typedef struct packed {
        logic [1:0] do_op;                          // Data-out select
        logic       we_next;                        // Write enable for next cycle
        logic [3:0] ab_mode;                        // Compressed address mode
        seq_op_e    seq;
        logic [6:0] reg_op;                         // Register file addressing
        alu_ctl_t   alu;                            // Also finisher slot when seq[1]
        logic [7:0] flag_sel;                       // Low 7 bits double as next address
    } ctl_word_t;

    // Address-logic control
    typedef struct packed {
        logic       iph;                            // Load PC high
        logic [5:0] abh;
        logic [1:0] abl_sel;
        logic [2:0] abl_ci;
    } ab_op_t;

    // Flag-update control
    typedef struct packed {
        logic [1:0] do_op;
        logic [7:0] flag_sel;
    } flags_t;

endpackage

// File: verilog/microcode_rom.sv
// Synchronous microcode ROM, 512 words of 31 bits
// Image comes from microcode.hex, unset words read as zero

module microcode_rom
    import ctl_pkg::*;
(
    input  logic                 clk,
    input  logic [UPC_WIDTH-1:0] upc,
    output ctl_word_t            ctrl
);

    logic [CTL_WIDTH-1:0] mem [ROM_DEPTH];          // Raw control words

    // Zero is "decode next opcode", so holes behave sanely
    initial begin
        for (int k = 0; k < ROM_DEPTH; k++) begin
            mem[k] = '0;                            // Fill before the sparse load
        end
        $readmemh("microcode.hex", mem);            // Image uses @ address markers
    end

    always_ff @(posedge clk) begin
        ctrl <= ctl_word_t'(mem[upc]);              // One cycle read latency
    end

endmodule

// File: verilog/irq_latch.sv
// Interrupt request latch
// Holds a request until an instruction boundary, masked by I

module irq_latch (
    input  logic clk,
    input  logic reset,
    input  logic irq,
    input  logic i,                                 // Interrupt disable flag
    input  logic sync,                              // Opcode decode cycle
    output logic take_irq
);

    logic pending;                                  // Request seen, not yet serviced
    logic taken;

    assign take_irq = pending & ~i;                 // Masked request to sequencer
    assign taken    = take_irq & sync;              // Sequencer branches to UPC_IRQ now

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (irq) begin
            pending <= 1'b1;                        // A held line keeps it pending
        end else if (taken) begin
            pending <= 1'b0;                        // Serviced
        end
    end

endmodule

// File: verilog/ctl_sequencer.sv
// Micro-program counter selection for the control unit
// Finisher slot register, registered write enable
// Splits the control word into the core's control outputs

module ctl_sequencer
    import ctl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 take_irq,
    input  logic                 d,                 // Decimal flag, picks ROM bank
    input  logic [7:0]           db,                // Opcode on the data bus
    input  ctl_word_t            ctrl,
    output logic [UPC_WIDTH-1:0] upc,
    output logic                 sync,
    output logic                 we,
    output logic                 b,
    output flags_t               flags,
    output alu_op_t              alu_op,
    output logic [6:0]           reg_op,
    output logic [1:0]           do_op
);

    logic [FIN_WIDTH-1:0] finish;                   // Saved finisher slot
    logic [FIN_WIDTH-1:0] fin_slot;                 // Slot carried in the ALU field
    logic                 fin_load;

    // When seq[1] is set the ALU is idle, its top bits name the finisher
    assign fin_slot = {ctrl.alu.shift, ctrl.alu.adder};
    assign fin_load = ctrl.seq[1];                  // SEQ_FINISH or SEQ_NEXT_SAVE

    always_comb begin
        if (reset) begin
            upc = UPC_RESET;
        end else begin
            case (ctrl.seq)
                SEQ_DECODE: begin
                    if (take_irq) begin
                        upc = UPC_IRQ;              // Interrupt sequence
                    end else begin
                        upc = {1'b0, db};           // Opcode indexes lower half
                    end
                end
                SEQ_NEXT, SEQ_NEXT_SAVE: begin
                    upc = {1'b1, d, ctrl.flag_sel[6:0]}; // Next word in current bank
                end
                default: begin
                    upc = {1'b1, d, UPC_FINISH_BASE, finish}; // Finisher area
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            we     <= 1'b0;
            finish <= '0;
        end else begin
            we <= ctrl.we_next;                     // Write strobe is one cycle late
            if (fin_load) begin
                finish <= fin_slot;
            end
        end
    end

    assign sync   = (ctrl.seq == SEQ_DECODE);       // Instruction boundary
    assign b      = ctrl.alu.ci[0];                 // Carry select unused during BRK push
    assign reg_op = ctrl.reg_op;
    assign do_op  = ctrl.do_op;

    assign alu_op = '{ci: ctrl.alu.ci, shift: ctrl.alu.shift, adder: ctrl.alu.adder};
    assign flags  = '{do_op: ctrl.do_op, flag_sel: ctrl.flag_sel};

endmodule

// File: verilog/ab_op_decoder.sv
// Address-mode expander for the address logic
// Four mode bits become iph, abh, abl_sel and abl_ci
// Relative branches use cond and the offset sign on the data bus

module ab_op_decoder
    import ctl_pkg::*;
(
    input  ctl_word_t ctrl,
    input  logic      cond,                         // Branch condition true
    input  logic      db7,                          // Sign of branch offset
    output ab_op_t    ab_op
);

    logic [6:0] hi;                                 // iph followed by abh
    logic [2:0] ci;                                 // abl_ci
    logic       used;                               // Mode exists in the table

    always_comb begin
        used = 1'b1;
        case (ctrl.ab_mode)
            4'd0:  {hi, ci} = {7'b0_011000, 3'b110}; // AB unchanged
            4'd1:  {hi, ci} = {7'b0_001010, 3'b100}; // Back to PC
            4'd2:  {hi, ci} = {7'b1_111011, 3'b010}; // DB high, ABL plus reg, save PC
            4'd3:  {hi, ci} = {7'b1_110000, 3'b010}; // Zero page, DB plus reg
            4'd4:  {hi, ci} = {7'b0_111000, 3'b111}; // AB plus one
            4'd5:  {hi, ci} = {7'b0_110110, 3'b001}; // Stack, SP plus one
            4'd6:  {hi, ci} = {7'b0_011011, 3'b010}; // DB high, ABL plus reg, PC kept
            4'd7: begin
                if (cond && db7) begin
                    {hi, ci} = {7'b0_111001, 3'b111}; // Taken backward, ABH minus one
                end else begin
                    {hi, ci} = {7'b0_111000, 3'b111}; // Forward or not taken
                end
            end
            4'd8:  {hi, ci} = {7'b0_011000, 3'b111}; // AB plus one, PC kept
            4'd9:  {hi, ci} = {7'b0_000110, 3'b000}; // Stack at SP, PC kept
            4'd10: {hi, ci} = {7'b1_110110, 3'b000}; // Stack at SP, PC plus one saved
            4'd11: {hi, ci} = {7'b0_100110, 3'b000}; // Stack at SP
            4'd12: {hi, ci} = {7'b0_001100, 3'b000}; // Page FF, reg low
            default: begin
                used     = 1'b0;                    // Not in the ROM
                {hi, ci} = '0;
            end
        endcase
    end

    always_comb begin
        if (used) begin
            ab_op = '{iph: hi[6], abh: hi[5:0], abl_sel: ctrl.ab_mode[1:0], abl_ci: ci};
        end else begin
            ab_op = '0;                             // Unused modes drive nothing
        end
    end

endmodule

// File: verilog/ctl_unit.sv
// Top level of the microcoded control unit
// Interrupt latch, sequencer, microcode ROM, address-mode decoder

module ctl_unit
    import ctl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       irq,
    input  logic       cond,                        // Branch condition from flags
    input  logic [7:0] db,                          // Data bus
    input  logic       i,                           // Interrupt disable
    input  logic       d,                           // Decimal mode
    output logic       sync,
    output logic       we,
    output flags_t     flags,
    output alu_op_t    alu_op,
    output logic [6:0] reg_op,
    output logic [1:0] do_op,
    output logic       b,
    output ab_op_t     ab_op
);

    logic                 take_irq;
    logic [UPC_WIDTH-1:0] upc;                      // ROM address
    ctl_word_t            ctrl;                     // Current control word

    irq_latch u_irq (
        .clk      (clk),
        .reset    (reset),
        .irq      (irq),
        .i        (i),
        .sync     (sync),
        .take_irq (take_irq)
    );

    ctl_sequencer u_seq (
        .clk      (clk),
        .reset    (reset),
        .take_irq (take_irq),
        .d        (d),
        .db       (db),
        .ctrl     (ctrl),
        .upc      (upc),
        .sync     (sync),
        .we       (we),
        .b        (b),
        .flags    (flags),
        .alu_op   (alu_op),
        .reg_op   (reg_op),
        .do_op    (do_op)
    );

    microcode_rom u_rom (
        .clk  (clk),
        .upc  (upc),
        .ctrl (ctrl)
    );

    ab_op_decoder u_abdec (
        .ctrl  (ctrl),
        .cond  (cond),
        .db7   (db[7]),                             // Offset sign only
        .ab_op (ab_op)
    );

endmodule

// File: verif/ctl_unit_checker.sv
// Concurrent assertions on the micro-sequencer
// Reset address, registered write enable, finisher hold, upc range

module ctl_unit_checker
    import ctl_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input ctl_word_t            ctrl,
    input logic [UPC_WIDTH-1:0] upc,
    input logic                 we,
    input logic [FIN_WIDTH-1:0] finish
);
    timeunit 1ns;
    timeprecision 100ps;

    reset_addr: assert property (@(posedge clk) reset |-> upc == UPC_RESET)
        else $error("upc left the reset entry while reset was high");

    we_delay: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> we == $past(ctrl.we_next))
        else $error("we does not follow the previous we_next");

    // Slot only reloads on finish or save-finisher words
    finish_hold: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(ctrl.seq[1])) |-> finish == $past(finish))
        else $error("finisher slot changed without seq upper bit");

    upc_upper: assert property (@(posedge clk) disable iff (reset)
        ctrl.seq != SEQ_DECODE |-> upc[UPC_WIDTH-1])
        else $error("sequenced upc fell into the opcode half");

endmodule

bind ctl_sequencer ctl_unit_checker u_check (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl),
    .upc    (upc),
    .we     (we),
    .finish (finish)
);

// File: verif/ctl_unit_tb.sv
// Testbench for the microcoded control unit
// LFSR stimulus, reference model fed from the ROM image, compare tasks
// Directed interrupt runs with I clear and with I set

module ctl_unit_tb
    import ctl_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 2000;
    localparam int WAIT_LIMIT   = 200;              // Cycles allowed to reach a sync
    localparam int MASK_CYCLES  = 24;               // Cycles with I held high

    logic       clk;
    logic       reset;
    logic       irq;
    logic       cond;
    logic [7:0] db;
    logic       i;
    logic       d;
    logic       sync;
    logic       we;
    logic       b;
    flags_t     flags;
    alu_op_t    alu_op;
    logic [6:0] reg_op;
    logic [1:0] do_op;
    ab_op_t     ab_op;

    logic [CTL_WIDTH-1:0] rom_m [ROM_DEPTH];        // Reference copy of the image
    ctl_word_t            ctrl_m;                   // Expected control word
    logic [FIN_WIDTH-1:0] fin_m;                    // Expected finisher slot
    logic                 pend_m;                   // Expected pending request
    logic                 we_m;
    logic [31:0]          lfsr;

    ctl_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;                         // 40 ns period
        end
    end

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [7:0] take_bits(input int count);
        logic [7:0] val;
        logic       fb;
        val = '0;
        for (int k = 0; k < count; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[6:0], fb};
        end
        return val;
    endfunction

    // Address-logic table giving {iph, abh, abl_ci} per mode
    function automatic ab_op_t ab_table(input logic [3:0] mode, input logic c, input logic s);
        logic [9:0] t;
        t = '0;
        case (mode)
            4'd0:  t = 10'b0_011000_110;
            4'd1:  t = 10'b0_001010_100;
            4'd2:  t = 10'b1_111011_010;
            4'd3:  t = 10'b1_110000_010;
            4'd4:  t = 10'b0_111000_111;
            4'd5:  t = 10'b0_110110_001;
            4'd6:  t = 10'b0_011011_010;
            4'd7:  t = (c && s) ? 10'b0_111001_111 : 10'b0_111000_111; // Backward branch
            4'd8:  t = 10'b0_011000_111;
            4'd9:  t = 10'b0_000110_000;
            4'd10: t = 10'b1_110110_000;
            4'd11: t = 10'b0_100110_000;
            4'd12: t = 10'b0_001100_000;
            default: return '0;                     // Modes 13 to 15 drive nothing
        endcase
        return '{iph: t[9], abh: t[8:3], abl_sel: mode[1:0], abl_ci: t[2:0]};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    task automatic mismatch(input string name, input string got, input string exp);
        report_failure($sformatf("Error: time %0t %s got %s expected %s", $time, name, got, exp));
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        if (got !== exp) mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic field_check(input string name, input logic [6:0] got, input logic [6:0] exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic flags_check(input string name, input flags_t got, input flags_t exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic alu_check(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic ab_check(input string name, input ab_op_t got, input ab_op_t exp);
        if (got !== exp) mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic outputs_check();
        bit_check("sync", sync, ctrl_m.seq == SEQ_DECODE);
        bit_check("we", we, we_m);
        bit_check("b", b, ctrl_m.alu.ci[0]);        // Low carry-in select bit
        field_check("reg_op", reg_op, ctrl_m.reg_op);
        field_check("do_op", {5'b0, do_op}, {5'b0, ctrl_m.do_op});
        flags_check("flags", flags, {ctrl_m.do_op, ctrl_m.flag_sel});
        alu_check("alu_op", alu_op, {ctrl_m.alu.ci, ctrl_m.alu.shift, ctrl_m.alu.adder});
        ab_check("ab_op", ab_op, ab_table(ctrl_m.ab_mode, cond, db[7]));
    endtask

    // Advance the model across the coming edge while inputs are stable
    task automatic step_model();
        logic [UPC_WIDTH-1:0] upc_m;
        logic                 take;
        take = pend_m & ~i;                         // Masked with I
        if (reset) begin
            upc_m = UPC_RESET;
        end else if (ctrl_m.seq == SEQ_DECODE) begin
            upc_m = take ? UPC_IRQ : {1'b0, db};
        end else if (ctrl_m.seq == SEQ_FINISH) begin
            upc_m = {1'b1, d, UPC_FINISH_BASE, fin_m};
        end else begin
            upc_m = {1'b1, d, ctrl_m.flag_sel[6:0]}; // Bank picked by d
        end
        if (reset) begin
            we_m   = 1'b0;
            fin_m  = '0;
            pend_m = 1'b0;
        end else begin
            we_m = ctrl_m.we_next;
            if (ctrl_m.seq[1]) fin_m = ctrl_m.alu[6:2]; // Slot rides in ALU field
            if (irq) pend_m = 1'b1;
            else if (take && ctrl_m.seq == SEQ_DECODE) pend_m = 1'b0;
        end
        ctrl_m = rom_m[upc_m];                      // One cycle ROM latency
    endtask

    task automatic drive_random();
        @(posedge clk);
        db   <= take_bits(8);
        cond <= |take_bits(1);
        d    <= |take_bits(1);
        i    <= (take_bits(2) == 8'h00);            // High a quarter of the time
        irq  <= (take_bits(5) == 8'h1f);            // Rare request
    endtask

    task automatic sample_cycle();
        @(negedge clk);
        if (!reset) outputs_check();
        step_model();
    endtask

    // Run with I low until a sync and expect the interrupt entry word after it
    task automatic expect_irq_entry(input string what);
        ctl_word_t entry;
        int        waited;
        logic      found;
        entry  = rom_m[UPC_IRQ];
        waited = 0;
        found  = 1'b0;
        while (!found && waited < WAIT_LIMIT) begin
            drive_random();
            irq <= 1'b0;
            i   <= 1'b0;
            @(negedge clk);
            outputs_check();
            found = sync;                           // Instruction boundary on the DUT
            step_model();
            waited++;
        end
        if (!found) report_failure({what, ": no instruction boundary before the timeout"});
        drive_random();
        @(negedge clk);
        outputs_check();
        field_check("reg_op at irq entry", reg_op, entry.reg_op);
        flags_check("flags at irq entry", flags, {entry.do_op, entry.flag_sel});
        step_model();
    endtask

    initial begin
        ctl_word_t rst_word;
        reset       = 1'b1;
        irq         = 1'b0;
        cond        = 1'b0;
        db          = '0;
        i           = 1'b0;
        d           = 1'b0;
        lfsr        = 32'h94e0;
        ctrl_m      = '0;
        fin_m       = '0;
        pend_m      = 1'b0;
        we_m        = 1'b0;
        for (int k = 0; k < ROM_DEPTH; k++) begin
            rom_m[k] = '0;
        end
        $readmemh("microcode.hex", rom_m);
        rst_word = rom_m[UPC_RESET];

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) reset <= 1'b0;
            sample_cycle();
        end
        bit_check("we after reset", we, 1'b0);
        field_check("reg_op after reset", reg_op, rst_word.reg_op);
        flags_check("flags after reset", flags, {rst_word.do_op, rst_word.flag_sel});

        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_random();
            sample_cycle();
        end

        drive_random();                             // Pulse with I clear
        irq <= 1'b1;
        i   <= 1'b0;
        sample_cycle();
        expect_irq_entry("irq with I clear");

        drive_random();                             // Pulse while masked
        irq <= 1'b1;
        i   <= 1'b1;
        sample_cycle();
        for (int c = 0; c < MASK_CYCLES; c++) begin
            drive_random();
            irq <= 1'b0;
            i   <= 1'b1;
            sample_cycle();
        end
        expect_irq_entry("irq held by I");

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: microcode.hex
// One 31-bit control word per entry, in hex; @ sets the word address
// Addresses not listed read as zero, which decodes the next opcode
@000 374ABC05 25C31E12 1A852D20 0C0F7788 61700120   // Opcodes 00 to 04
@080 42D00003 73470FAA 0B000000 5965A5A1            // Opcodes 80 to 83
@103 17800000                                       // Finish to saved slot
@105 08400006 14C2190A                              // Save finisher 06
@10A 26400C0B 00800000
@112 04400013 09800000                              // Finish to slot 07
@120 0B800000 18C0F42C                              // Save finisher 1D
@12A 07400060 00000000 03800000                     // Jump into reset sequence
@140 12345678                                       // Finisher slots, bank 0
@146 30000155 60000000
@14A 4B000000
@15D 1B00ABCD
@160 05400061 2A000000                              // Reset sequence
@168 3AC0A870                                       // Interrupt entry, save slot 0A
@170 19800000
@185 0780000C                                       // Bank 1 words
@192 0A800000
@1C7 7C000000 00000000 00000000 56000000            // Finisher slots, bank 1
@1F0 0C800000

// File: verilog.f
verilog/ctl_pkg.sv
verilog/microcode_rom.sv
verilog/irq_latch.sv
verilog/ctl_sequencer.sv
verilog/ab_op_decoder.sv
verilog/ctl_unit.sv
verif/ctl_unit_checker.sv
verif/ctl_unit_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = ctl_unit_tb
FILELIST = verilog.f

SOURCES := $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir obj_dir -f $(FILELIST)

run: $(BIN) microcode.hex
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
